// ==== source/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // decoded operation, one entry per distinct behavior
    typedef enum logic [5:0] {
        op_sll,   op_srl,   op_sra,   op_sllv,
        op_srlv,  op_srav,  op_mult,  op_multu,
        op_div,   op_divu,  op_mthi,  op_mtlo,
        op_add,   op_addu,  op_subu,  op_and,
        op_or,    op_xor,   op_nor,   op_slt,
        op_sltu,  op_bgez,  op_bltz,  op_beq,
        op_bne,   op_blez,  op_bgtz,  op_addi,
        op_addiu, op_slti,  op_sltiu, op_andi,
        op_ori,   op_xori,  op_lui,   op_mem,
        op_none
    } alu_op_e;

    // what a retirement carries
    typedef enum logic [2:0] {
        rk_none,    // undefined opcode/funct
        rk_gpr,     // value goes to rd/rt
        rk_hilo,    // hi and lo both written
        rk_hi,      // MTHI
        rk_lo,      // MTLO
        rk_branch,  // taken flag only
        rk_addr     // load/store effective address
    } result_kind_e;

    typedef struct packed {
        logic [31:0] instr;  // raw instruction word
        logic [31:0] op1;    // rs value
        logic [31:0] op2;    // rt value
    } issue_t;

    typedef struct packed {
        alu_op_e     op;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [15:0] imm16;
        logic [4:0]  shamt;
    } lane_op_t;

    typedef struct packed {
        result_kind_e kind;
        logic [31:0]  value;  // gpr result, address or mthi/mtlo data
        logic [31:0]  hi;
        logic [31:0]  lo;
        logic         taken;
    } retire_t;

endpackage

`default_nettype wire

// ==== source/iter_divider.sv ====
`default_nettype none

module iter_divider (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        is_signed,
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    output logic        done,
    output logic [31:0] quotient,
    output logic [31:0] remainder
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_fix
    } div_state_e;

    div_state_e  state;
    logic [4:0]  step;
    logic [31:0] dvs_mag;
    logic [31:0] quo_mag;   // shifts dividend out, quotient in
    logic [31:0] rem_mag;
    logic        neg_quo;
    logic        neg_rem;
    logic        by_zero;
    logic [32:0] trial;

    assign trial = {rem_mag, quo_mag[31]} - {1'b0, dvs_mag};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        step  <= '0;
                    end
                end
                st_run: begin
                    step <= step + 1'b1;
                    if (step == 5'd31) begin
                        state <= st_fix;
                    end
                end
                default: state <= st_idle;  // fix lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo_mag <= (is_signed && dividend[31]) ? -dividend : dividend;
            dvs_mag <= (is_signed && divisor[31]) ? -divisor : divisor;
            rem_mag <= '0;
            neg_quo <= is_signed && (dividend[31] ^ divisor[31]);
            neg_rem <= is_signed && dividend[31];  // remainder follows dividend
            by_zero <= (divisor == '0);
        end else if (state == st_run) begin
            quo_mag <= {quo_mag[30:0], ~trial[32]};
            rem_mag <= trial[32] ? {rem_mag[30:0], quo_mag[31]} : trial[31:0];
        end
    end

    // sign fix stays valid after done until the next start
    assign done      = (state == st_fix);
    assign quotient  = by_zero ? '1 : (neg_quo ? -quo_mag : quo_mag);
    assign remainder = neg_rem ? -rem_mag : rem_mag;

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (reset) start |-> state == st_idle);

endmodule

`default_nettype wire

// ==== source/alu_lane.sv ====
`default_nettype none

module alu_lane import exec_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  lane_op_t in_op,
    output logic     out_valid,
    input  logic     out_ready,
    output retire_t  out_res
);

    lane_op_t           op_q;       // accepted operation
    logic               full;
    logic               div_have;   // divider result latched as ready
    logic               is_div_q;
    logic               accept;
    logic               drain;
    logic               div_start;
    logic               div_done;
    logic [31:0]        div_quo;
    logic [31:0]        div_rem;
    logic [31:0]        simm;
    logic [31:0]        uimm;
    logic               prod_signed;
    logic signed [65:0] prod;
    retire_t            res_c;

    assign accept   = in_valid && in_ready;
    assign drain    = out_valid && out_ready;
    assign in_ready = !full;

    // divider latches its operands straight from the input on accept
    assign div_start = accept && (in_op.op == op_div || in_op.op == op_divu);
    assign is_div_q  = (op_q.op == op_div) || (op_q.op == op_divu);

    always_ff @(posedge clk) begin
        if (reset) begin
            full     <= 1'b0;
            div_have <= 1'b0;
        end else begin
            if (accept) begin
                full <= 1'b1;
            end else if (drain) begin
                full <= 1'b0;
            end
            if (drain) begin
                div_have <= 1'b0;
            end else if (div_done) begin
                div_have <= 1'b1;  // hold after the done pulse
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= in_op;
        end
    end

    iter_divider u_div (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (in_op.op == op_div),
        .dividend  (in_op.op1),
        .divisor   (in_op.op2),
        .done      (div_done),
        .quotient  (div_quo),
        .remainder (div_rem)
    );

    assign simm = {{16{op_q.imm16[15]}}, op_q.imm16};
    assign uimm = {16'b0, op_q.imm16};

    // one 33x33 signed multiplier covers MULT and MULTU
    assign prod_signed = (op_q.op == op_mult);
    assign prod = $signed({prod_signed & op_q.op1[31], op_q.op1})
                * $signed({prod_signed & op_q.op2[31], op_q.op2});

    always_comb begin
        res_c = '0;
        res_c.kind = rk_gpr;
        case (op_q.op)
            op_sll:   res_c.value = op_q.op2 << op_q.shamt;
            op_srl:   res_c.value = op_q.op2 >> op_q.shamt;
            op_sra:   res_c.value = $signed(op_q.op2) >>> op_q.shamt;
            op_sllv:  res_c.value = op_q.op2 << op_q.op1[4:0];
            op_srlv:  res_c.value = op_q.op2 >> op_q.op1[4:0];
            op_srav:  res_c.value = $signed(op_q.op2) >>> op_q.op1[4:0];
            op_add,
            op_addu:  res_c.value = op_q.op1 + op_q.op2;  // no overflow trap
            op_subu:  res_c.value = op_q.op1 - op_q.op2;
            op_and:   res_c.value = op_q.op1 & op_q.op2;
            op_or:    res_c.value = op_q.op1 | op_q.op2;
            op_xor:   res_c.value = op_q.op1 ^ op_q.op2;
            op_nor:   res_c.value = ~(op_q.op1 | op_q.op2);
            op_slt:   res_c.value = {31'b0, $signed(op_q.op1) < $signed(op_q.op2)};
            op_sltu:  res_c.value = {31'b0, op_q.op1 < op_q.op2};
            op_addi,
            op_addiu: res_c.value = op_q.op1 + simm;
            op_slti:  res_c.value = {31'b0, $signed(op_q.op1) < $signed(simm)};
            op_sltiu: res_c.value = {31'b0, op_q.op1 < simm};  // unsigned vs sext imm
            op_andi:  res_c.value = op_q.op1 & uimm;
            op_ori:   res_c.value = op_q.op1 | uimm;
            op_xori:  res_c.value = op_q.op1 ^ uimm;
            op_lui:   res_c.value = {op_q.imm16, 16'b0};
            op_mult,
            op_multu: begin
                res_c.kind = rk_hilo;
                res_c.hi   = prod[63:32];
                res_c.lo   = prod[31:0];
            end
            op_div,
            op_divu: begin
                res_c.kind = rk_hilo;
                res_c.hi   = div_rem;
                res_c.lo   = div_quo;
            end
            op_mthi: begin
                res_c.kind  = rk_hi;
                res_c.value = op_q.op1;
            end
            op_mtlo: begin
                res_c.kind  = rk_lo;
                res_c.value = op_q.op1;
            end
            op_bgez,
            op_bltz,
            op_beq,
            op_bne,
            op_blez,
            op_bgtz: begin
                res_c.kind = rk_branch;
                case (op_q.op)
                    op_bgez: res_c.taken = !op_q.op1[31];
                    op_bltz: res_c.taken = op_q.op1[31];
                    op_beq:  res_c.taken = (op_q.op1 == op_q.op2);
                    op_bne:  res_c.taken = (op_q.op1 != op_q.op2);
                    op_blez: res_c.taken = op_q.op1[31] || (op_q.op1 == '0);
                    default: res_c.taken = !op_q.op1[31] && (op_q.op1 != '0);  // bgtz
                endcase
            end
            op_mem: begin
                res_c.kind  = rk_addr;
                res_c.value = op_q.op1 + simm;  // base plus offset
            end
            default:  res_c.kind = rk_none;
        endcase
    end

    assign out_res   = res_c;
    assign out_valid = full && (!is_div_q || div_done || div_have);

    a_res_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_res));

endmodule

`default_nettype wire

// ==== source/issue_dispatch.sv ====
`default_nettype none

module issue_dispatch import exec_pkg::*; #(
    parameter int num_lanes = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue_valid,
    output logic                 issue_ready,
    input  issue_t               issue,
    output logic [num_lanes-1:0] lane_valid,
    input  logic [num_lanes-1:0] lane_ready,
    output lane_op_t             lane_op [num_lanes]
);

    localparam int idx_w = $clog2(num_lanes);

    logic [idx_w-1:0] ptr;   // next lane to receive
    logic [5:0]       opcode;
    logic [5:0]       funct;
    logic [4:0]       rt;
    alu_op_e          op_dec;
    lane_op_t         pkt;

    assign opcode = issue.instr[31:26];
    assign funct  = issue.instr[5:0];
    assign rt     = issue.instr[20:16];

    always_comb begin
        op_dec = op_none;
        case (opcode)
            6'd0: begin
                case (funct)
                    6'd0:  op_dec = op_sll;
                    6'd2:  op_dec = op_srl;
                    6'd3:  op_dec = op_sra;
                    6'd4:  op_dec = op_sllv;
                    6'd6:  op_dec = op_srlv;
                    6'd7:  op_dec = op_srav;
                    6'd17: op_dec = op_mthi;
                    6'd19: op_dec = op_mtlo;
                    6'd24: op_dec = op_mult;
                    6'd25: op_dec = op_multu;
                    6'd26: op_dec = op_div;
                    6'd27: op_dec = op_divu;
                    6'd32: op_dec = op_add;
                    6'd33: op_dec = op_addu;
                    6'd35: op_dec = op_subu;
                    6'd36: op_dec = op_and;
                    6'd37: op_dec = op_or;
                    6'd38: op_dec = op_xor;
                    6'd39: op_dec = op_nor;
                    6'd42: op_dec = op_slt;
                    6'd43: op_dec = op_sltu;
                    default: op_dec = op_none;
                endcase
            end
            6'd1: begin  // REGIMM, rt selects the branch
                case (rt)
                    5'd0, 5'd16: op_dec = op_bltz;  // bltz, bltzal
                    5'd1, 5'd17: op_dec = op_bgez;  // bgez, bgezal
                    default:     op_dec = op_none;
                endcase
            end
            6'd4:  op_dec = op_beq;
            6'd5:  op_dec = op_bne;
            6'd6:  op_dec = op_blez;
            6'd7:  op_dec = op_bgtz;
            6'd8:  op_dec = op_addi;
            6'd9:  op_dec = op_addiu;
            6'd10: op_dec = op_slti;
            6'd11: op_dec = op_sltiu;
            6'd12: op_dec = op_andi;
            6'd13: op_dec = op_ori;
            6'd14: op_dec = op_xori;
            6'd15: op_dec = op_lui;
            6'd32, 6'd33, 6'd34, 6'd35, 6'd36,
            6'd37, 6'd38, 6'd40, 6'd41, 6'd43: op_dec = op_mem;  // loads and stores
            default: op_dec = op_none;
        endcase
    end

    always_comb begin
        pkt.op    = op_dec;
        pkt.op1   = issue.op1;
        pkt.op2   = issue.op2;
        pkt.imm16 = issue.instr[15:0];
        pkt.shamt = issue.instr[10:6];
        for (int i = 0; i < num_lanes; i++) begin
            lane_valid[i] = issue_valid && (ptr == idx_w'(i));
            lane_op[i]    = pkt;  // only the selected lane sees valid
        end
    end

    assign issue_ready = lane_ready[ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (issue_valid && issue_ready) begin
            ptr <= (ptr == idx_w'(num_lanes - 1)) ? '0 : ptr + 1'b1;  // wrap
        end
    end

    a_lane_valid_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(lane_valid));

endmodule

`default_nettype wire

// ==== source/retire_collector.sv ====
`default_nettype none

module retire_collector import exec_pkg::*; #(
    parameter int num_lanes = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [num_lanes-1:0] res_valid,
    output logic [num_lanes-1:0] res_ready,
    input  retire_t              res [num_lanes],
    output logic                 retire_valid,
    input  logic                 retire_ready,
    output retire_t              retire,
    output logic [31:0]          hi,
    output logic [31:0]          lo
);

    localparam int idx_w = $clog2(num_lanes);

    logic [idx_w-1:0] ptr;   // lane to drain next
    logic             xfer;
    logic             hilo_wr;

    assign retire_valid = res_valid[ptr];
    assign retire       = res[ptr];
    assign xfer         = retire_valid && retire_ready;
    assign hilo_wr      = xfer && (retire.kind inside {rk_hilo, rk_hi, rk_lo});

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            res_ready[i] = retire_ready && (ptr == idx_w'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (xfer) begin
            ptr <= (ptr == idx_w'(num_lanes - 1)) ? '0 : ptr + 1'b1;
        end
    end

    // architectural hi/lo
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (hilo_wr) begin
            case (retire.kind)
                rk_hilo: begin
                    hi <= retire.hi;
                    lo <= retire.lo;
                end
                rk_hi:   hi <= retire.value;  // MTHI
                default: lo <= retire.value;  // MTLO
            endcase
        end
    end

    a_hilo_write: assert property (
        @(posedge clk) disable iff (reset)
        ($changed(hi) || $changed(lo)) |-> $past(hilo_wr));

endmodule

`default_nettype wire

// ==== source/exec_cluster.sv ====
`default_nettype none

module exec_cluster import exec_pkg::*; #(
    parameter int num_lanes = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        issue_valid,
    output logic        issue_ready,
    input  issue_t      issue,
    output logic        retire_valid,
    input  logic        retire_ready,
    output retire_t     retire,
    output logic [31:0] hi,
    output logic [31:0] lo
);

    logic [num_lanes-1:0] lane_valid;
    logic [num_lanes-1:0] lane_ready;
    lane_op_t             lane_op [num_lanes];
    logic [num_lanes-1:0] res_valid;
    logic [num_lanes-1:0] res_ready;
    retire_t              res [num_lanes];

    issue_dispatch #(
        .num_lanes (num_lanes)
    ) u_dispatch (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .lane_valid  (lane_valid),
        .lane_ready  (lane_ready),
        .lane_op     (lane_op)
    );

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        alu_lane u_lane (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (lane_valid[i]),
            .in_ready  (lane_ready[i]),
            .in_op     (lane_op[i]),
            .out_valid (res_valid[i]),
            .out_ready (res_ready[i]),
            .out_res   (res[i])
        );
    end

    retire_collector #(
        .num_lanes (num_lanes)
    ) u_collect (
        .clk          (clk),
        .reset        (reset),
        .res_valid    (res_valid),
        .res_ready    (res_ready),
        .res          (res),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire),
        .hi           (hi),
        .lo           (lo)
    );

endmodule

`default_nettype wire

// ==== tests/exec_model.svh ====
`ifndef exec_model_svh
`define exec_model_svh

// right shift with the sign bit filled in from the left
function automatic logic [31:0] shift_arith(input logic [31:0] v, input logic [4:0] n);
    return (v >> n) | (v[31] ? ~(32'hffff_ffff >> n) : 32'h0);
endfunction

// signed compare built from the sign bits and an unsigned compare
function automatic logic less_signed(input logic [31:0] x, input logic [31:0] y);
    return (x[31] != y[31]) ? x[31] : (x < y);
endfunction

function automatic retire_t model_divide(input logic [31:0] a, input logic [31:0] b,
                                         input bit sgn);
    retire_t r;
    longint  x;
    longint  y;
    r = '0;
    r.kind = rk_hilo;
    if (b == '0) begin
        r.lo = '1;  // quotient all ones
        r.hi = a;   // remainder is the dividend
    end else begin
        x = sgn ? longint'($signed(a)) : longint'(a);
        y = sgn ? longint'($signed(b)) : longint'(b);
        r.lo = 32'(x / y);  // truncates toward zero
        r.hi = 32'(x % y);  // sign of dividend
    end
    return r;
endfunction

function automatic retire_t model_exec(input issue_t it);
    retire_t     r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] ze;
    logic [4:0]  sa;
    logic [63:0] prod;
    a  = it.op1;
    b  = it.op2;
    se = {{16{it.instr[15]}}, it.instr[15:0]};
    ze = {16'h0, it.instr[15:0]};
    sa = it.instr[10:6];
    r = '0;
    r.kind = rk_gpr;
    case (it.instr[31:26])
        6'd0: begin
            case (it.instr[5:0])
                6'd0:  r.value = b << sa;
                6'd2:  r.value = b >> sa;
                6'd3:  r.value = shift_arith(b, sa);
                6'd4:  r.value = b << a[4:0];
                6'd6:  r.value = b >> a[4:0];
                6'd7:  r.value = shift_arith(b, a[4:0]);
                6'd17: begin
                    r.kind  = rk_hi;
                    r.value = a;
                end
                6'd19: begin
                    r.kind  = rk_lo;
                    r.value = a;
                end
                6'd24, 6'd25: begin
                    r.kind = rk_hilo;
                    if (it.instr[0]) prod = {32'h0, a} * {32'h0, b};
                    else prod = longint'($signed(a)) * longint'($signed(b));
                    r.hi = prod[63:32];
                    r.lo = prod[31:0];
                end
                6'd26, 6'd27: r = model_divide(a, b, !it.instr[0]);
                6'd32, 6'd33: r.value = a + b;  // add acts as addu
                6'd35: r.value = a - b;
                6'd36: r.value = a & b;
                6'd37: r.value = a | b;
                6'd38: r.value = a ^ b;
                6'd39: r.value = ~(a | b);
                6'd42: r.value = {31'h0, less_signed(a, b)};
                6'd43: r.value = {31'h0, a < b};
                default: r.kind = rk_none;
            endcase
        end
        6'd1: begin
            r.kind = rk_branch;
            case (it.instr[20:16])
                5'd0, 5'd16: r.taken = a[31];   // bltz, bltzal
                5'd1, 5'd17: r.taken = !a[31];  // bgez, bgezal
                default:     r.kind  = rk_none;
            endcase
        end
        6'd4, 6'd5, 6'd6, 6'd7: begin
            r.kind = rk_branch;
            case (it.instr[27:26])
                2'd0: r.taken = (a == b);
                2'd1: r.taken = (a != b);
                2'd2: r.taken = a[31] || (a == 0);
                default: r.taken = !a[31] && (a != 0);
            endcase
        end
        6'd8, 6'd9: r.value = a + se;
        6'd10: r.value = {31'h0, less_signed(a, se)};
        6'd11: r.value = {31'h0, a < se};  // both taken unsigned
        6'd12: r.value = a & ze;
        6'd13: r.value = a | ze;
        6'd14: r.value = a ^ ze;
        6'd15: r.value = {it.instr[15:0], 16'h0};
        6'd32, 6'd33, 6'd34, 6'd35, 6'd36,
        6'd37, 6'd38, 6'd40, 6'd41, 6'd43: begin
            r.kind  = rk_addr;
            r.value = a + se;  // base plus offset
        end
        default: r.kind = rk_none;
    endcase
    return r;
endfunction

task automatic check_retire(input retire_t got, input retire_t exp);
    if (got.kind !== exp.kind)
        fail_run($sformatf("ERROR: retire.kind got %h expected %h", got.kind, exp.kind));
    if (got.value !== exp.value)
        fail_run($sformatf("ERROR: retire.value got %h expected %h", got.value, exp.value));
    if (got.hi !== exp.hi)
        fail_run($sformatf("ERROR: retire.hi got %h expected %h", got.hi, exp.hi));
    if (got.lo !== exp.lo)
        fail_run($sformatf("ERROR: retire.lo got %h expected %h", got.lo, exp.lo));
    if (got.taken !== exp.taken)
        fail_run($sformatf("ERROR: retire.taken got %h expected %h", got.taken, exp.taken));
endtask

task automatic check_hilo(input logic [31:0] got_hi, input logic [31:0] got_lo);
    if (got_hi !== model_hi)
        fail_run($sformatf("ERROR: hi got %h expected %h", got_hi, model_hi));
    if (got_lo !== model_lo)
        fail_run($sformatf("ERROR: lo got %h expected %h", got_lo, model_lo));
endtask

`endif

// ==== tests/exec_cluster_tb.sv ====
`default_nettype none

module exec_cluster_tb import exec_pkg::*; ();

    localparam int clk_period = 8;
    localparam int n_ops      = 3000;
    localparam int n_random   = 2700;  // the rest runs back to back, no divides

    // defined functs first, then three undefined ones
    localparam logic [24*6-1:0] r_functs = {
        6'd0,  6'd2,  6'd3,  6'd4,  6'd6,  6'd7,  6'd17, 6'd19,
        6'd24, 6'd25, 6'd26, 6'd27, 6'd32, 6'd33, 6'd35, 6'd36,
        6'd37, 6'd38, 6'd39, 6'd42, 6'd43, 6'd1,  6'd5,  6'd63
    };
    localparam logic [10*6-1:0] mem_opcodes = {
        6'd32, 6'd33, 6'd34, 6'd35, 6'd36, 6'd37, 6'd38, 6'd40, 6'd41, 6'd43
    };
    localparam logic [5*5-1:0]  regimm_rts  = {5'd0, 5'd1, 5'd16, 5'd17, 5'd2};
    localparam logic [4*6-1:0]  bad_opcodes = {6'd2, 6'd3, 6'd16, 6'd63};

    logic        clk;
    logic        reset;
    logic        issue_valid;
    logic        issue_ready;
    issue_t      issue;
    logic        retire_valid;
    logic        retire_ready;
    retire_t     retire;
    logic [31:0] hi;
    logic [31:0] lo;

    integer      seed = 32'h4133_a3db;
    retire_t     exp_q [$];   // expected retirements in issue order
    int          cyc_q [$];   // cycle of each accepted issue
    logic [31:0] model_hi;
    logic [31:0] model_lo;
    int          n_issued;
    int          n_retired;
    int          cyc;
    logic        fired;

    exec_cluster #(
        .num_lanes (4)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire),
        .hi           (hi),
        .lo           (lo)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    `include "exec_model.svh"

    function automatic int unsigned draw(input int unsigned n);
        int unsigned r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic issue_t make_issue(input bit no_div);
        issue_t      it;
        int unsigned pick;
        logic [5:0]  fn;
        it.instr = $random(seed);
        it.op1   = $random(seed);
        it.op2   = $random(seed);
        case (draw(8))
            0: it.op2 = it.op1;          // equal operands for beq/bne/slt
            1: it.op1 = '0;              // blez/bgtz boundary
            2: begin
                it.op1 = 32'h8000_0000;  // most negative over minus one
                it.op2 = '1;
            end
            default: ;
        endcase
        pick = draw(16);
        if (pick < 7) begin
            fn = r_functs[draw(24)*6 +: 6];
            if (no_div && fn inside {6'd26, 6'd27}) fn = 6'd33;
            if (fn inside {6'd26, 6'd27} && draw(8) == 0) it.op2 = '0;
            it.instr[31:26] = 6'd0;
            it.instr[5:0]   = fn;
        end else if (pick < 9) begin
            it.instr[31:26] = 6'd1;
            it.instr[20:16] = regimm_rts[draw(5)*5 +: 5];
        end else if (pick < 13) begin
            it.instr[31:26] = 6'd4 + 6'(draw(12));  // branches and immediates
        end else if (pick < 15) begin
            it.instr[31:26] = mem_opcodes[draw(10)*6 +: 6];
        end else begin
            it.instr[31:26] = bad_opcodes[draw(4)*6 +: 6];
        end
        return it;
    endfunction

    task automatic drive_inputs(input int limit, input bit strict);
        if (!issue_valid || fired) begin
            if (n_issued < limit && (strict || draw(4) != 0)) begin
                issue       = make_issue(strict);
                issue_valid = 1'b1;
            end else begin
                issue_valid = 1'b0;
            end
        end
        retire_ready = strict || (draw(4) != 0);
    endtask

    // sampled mid-cycle, ahead of the edge that does the transfer
    task automatic monitor(input bit strict);
        retire_t exp;
        int      issued_at;
        cyc++;
        check_hilo(hi, lo);
        if (retire_valid && retire_ready) begin
            if (exp_q.size() == 0) begin
                fail_run("a retirement arrived with no instruction outstanding");
            end else begin
                exp       = exp_q.pop_front();
                issued_at = cyc_q.pop_front();
                check_retire(retire, exp);
                if (strict && cyc - issued_at != 1)
                    fail_run($sformatf("a retirement took %0d cycles instead of one",
                                       cyc - issued_at));
                case (exp.kind)
                    rk_hilo: begin
                        model_hi = exp.hi;
                        model_lo = exp.lo;
                    end
                    rk_hi:   model_hi = exp.value;
                    rk_lo:   model_lo = exp.value;
                    default: ;
                endcase
                n_retired++;
            end
        end
        fired = issue_valid && issue_ready;
        if (fired) begin
            exp_q.push_back(model_exec(issue));
            cyc_q.push_back(cyc);
            n_issued++;
        end
    endtask

    task automatic run_cycle(input int limit, input bit strict);
        drive_inputs(limit, strict);
        @(negedge clk);
        monitor(strict);
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((n_ops * 40 + 3) * clk_period);
        fail_run("watchdog expired before all operations retired");
    end

    initial begin
        reset        = 1'b1;
        issue_valid  = 1'b0;
        issue        = '0;
        retire_ready = 1'b0;
        fired        = 1'b0;
        model_hi     = '0;
        model_lo     = '0;
        n_issued     = 0;
        n_retired    = 0;
        cyc          = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        while (n_retired < n_random) run_cycle(n_random, 1'b0);
        while (n_retired < n_ops) run_cycle(n_ops, 1'b1);
        repeat (40) run_cycle(n_ops, 1'b1);  // nothing more may retire
        if (exp_q.size() != 0 || n_issued != n_retired) begin
            fail_run($sformatf("%0d issued but %0d retired", n_issued, n_retired));
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+tests
source/exec_pkg.sv
source/iter_divider.sv
source/alu_lane.sv
source/issue_dispatch.sv
source/retire_collector.sv
source/exec_cluster.sv
tests/exec_cluster_tb.sv

// ==== Bender.yml ====
package:
  name: exec_cluster

sources:
  - source/exec_pkg.sv
  - source/iter_divider.sv
  - source/alu_lane.sv
  - source/issue_dispatch.sv
  - source/retire_collector.sv
  - source/exec_cluster.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/exec_cluster_tb.sv
